//--- design/aw_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module aw_addr_decode
    import axi_demux_pkg::*;
#(
    parameter int num_slaves = num_slaves_default,
    parameter addr_t [num_slaves-1:0] slave_base = '0,
    parameter addr_t [num_slaves-1:0] slave_mask = '0,
    localparam int slave_width = (num_slaves > 1) ? $clog2(num_slaves) : 1
) (
    input  addr_t                  addr,
    output logic [slave_width-1:0] aw_slave
);

    // One bit per slave window that the address falls into
    logic [num_slaves-1:0] win_hit;

    // A window with an all-zero mask is treated as unused and never matches
    for (genvar i = 0; i < num_slaves; i++) begin : g_match
        assign win_hit[i] = (slave_mask[i] != '0) && ((addr & ~slave_mask[i]) == slave_base[i]);
    end

    // Walk from the top down so that the lowest matching slave wins
    // An address outside every window falls back to slave 0
    always_comb begin
        aw_slave = '0;
        for (int i = num_slaves - 1; i >= 0; i--) begin
            if (win_hit[i]) begin
                aw_slave = slave_width'(i);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/aw_w_router.sv
`timescale 1ns/1ps
`default_nettype none

module aw_w_router
    import axi_demux_pkg::*;
#(
    parameter int num_slaves = num_slaves_default,
    localparam int slave_width = (num_slaves > 1) ? $clog2(num_slaves) : 1
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   aw_forward,
    input  logic [slave_width-1:0] aw_slave,
    input  logic                   m_aw_valid,
    input  w_beat_t                m_w,
    input  logic                   m_w_valid,
    input  logic [num_slaves-1:0]  s_aw_ready,
    input  logic [num_slaves-1:0]  s_w_ready,
    output logic                   m_aw_ready,
    output logic                   m_w_ready,
    output logic [num_slaves-1:0]  s_aw_valid,
    output logic [num_slaves-1:0]  s_w_valid,
    output logic                   aw_fire
);

    // AW and W are not ordered against each other on AXI, so each keeps its own lock
    // The address lock stays until the AW handshake and the data lock until the last W beat
    logic                   aw_locked;
    logic                   w_locked;
    logic [slave_width-1:0] aw_selected;
    logic                   w_last_fire;

    // Ready comes straight from the selected slave, gated by the lock
    assign m_aw_ready = aw_locked && s_aw_ready[aw_selected];
    assign m_w_ready  = w_locked && s_w_ready[aw_selected];

    assign aw_fire     = m_aw_valid && m_aw_ready;
    assign w_last_fire = m_w_valid && m_w_ready && m_w.last;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aw_locked   <= 1'b0;
            w_locked    <= 1'b0;
            aw_selected <= '0;
        end else if (aw_locked || w_locked) begin
            // Either lock may drop first; a new AW waits for both
            if (aw_fire) begin
                aw_locked <= 1'b0;
            end
            if (w_last_fire) begin
                w_locked <= 1'b0;
            end
        end else if (aw_forward) begin
            // The slave choice is frozen here for the AW and the whole W burst
            aw_locked   <= 1'b1;
            w_locked    <= 1'b1;
            aw_selected <= aw_slave;
        end
    end

    // Payloads go to every slave and only the selected one sees a valid
    for (genvar i = 0; i < num_slaves; i++) begin : g_valid
        assign s_aw_valid[i] = aw_locked && (aw_selected == slave_width'(i));
        // W beats pass through without a register while the data lock is held
        assign s_w_valid[i]  = w_locked && (aw_selected == slave_width'(i)) && m_w_valid;
    end

endmodule

`default_nettype wire

//--- design/axi_demux_pkg.sv
`default_nettype none

package axi_demux_pkg;

    // Field types of the write channels
    typedef logic [3:0]  id_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    // Burst length is stored as the beat count minus one, as on the AXI bus
    typedef logic [7:0]  len_t;
    typedef logic [1:0]  resp_t;

    // AW channel payload, broadcast to every slave port
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } aw_req_t;

    // One W beat, also broadcast to every slave port
    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    // B channel payload returned by a slave
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_rsp_t;

    // Default number of slave ports behind the demux
    localparam int num_slaves_default = 3;

    // Default width of the per-ID pending write counter
    localparam int cnt_width_default = 4;

endpackage

`default_nettype wire

//--- design/axi_wr_demux.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_demux
    import axi_demux_pkg::*;
#(
    parameter int num_slaves = num_slaves_default,
    parameter int cnt_width  = cnt_width_default,
    parameter addr_t [num_slaves-1:0] slave_base = '0,
    parameter addr_t [num_slaves-1:0] slave_mask = '0,
    localparam int slave_width = (num_slaves > 1) ? $clog2(num_slaves) : 1
) (
    input  logic                     clk,
    input  logic                     rstn,
    // Master side
    input  aw_req_t                  m_aw,
    input  logic                     m_aw_valid,
    output logic                     m_aw_ready,
    input  w_beat_t                  m_w,
    input  logic                     m_w_valid,
    output logic                     m_w_ready,
    output b_rsp_t                   m_b,
    output logic                     m_b_valid,
    input  logic                     m_b_ready,
    // Slave side
    output aw_req_t [num_slaves-1:0] s_aw,
    output logic [num_slaves-1:0]    s_aw_valid,
    input  logic [num_slaves-1:0]    s_aw_ready,
    output w_beat_t [num_slaves-1:0] s_w,
    output logic [num_slaves-1:0]    s_w_valid,
    input  logic [num_slaves-1:0]    s_w_ready,
    input  b_rsp_t [num_slaves-1:0]  s_b,
    input  logic [num_slaves-1:0]    s_b_valid,
    output logic [num_slaves-1:0]    s_b_ready
);

    logic [slave_width-1:0] aw_slave;
    logic                   aw_forward;
    logic                   aw_fire;
    logic                   b_fire;

    // Payloads fan out unchanged and steering is done by the valids alone
    for (genvar i = 0; i < num_slaves; i++) begin : g_bcast
        assign s_aw[i] = m_aw;
        assign s_w[i]  = m_w;
    end

    // A retired response frees one pending slot of its ID
    assign b_fire = m_b_valid && m_b_ready;

    aw_addr_decode #(
        .num_slaves (num_slaves),
        .slave_base (slave_base),
        .slave_mask (slave_mask)
    ) u_decode (
        .addr     (m_aw.addr),
        .aw_slave (aw_slave)
    );

    id_order_table #(
        .num_slaves (num_slaves),
        .cnt_width  (cnt_width)
    ) u_order (
        .clk        (clk),
        .rstn       (rstn),
        .aw_id      (m_aw.id),
        .aw_slave   (aw_slave),
        .aw_valid   (m_aw_valid),
        .aw_fire    (aw_fire),
        .b_id       (m_b.id),
        .b_fire     (b_fire),
        .aw_forward (aw_forward)
    );

    aw_w_router #(
        .num_slaves (num_slaves)
    ) u_router (
        .clk        (clk),
        .rstn       (rstn),
        .aw_forward (aw_forward),
        .aw_slave   (aw_slave),
        .m_aw_valid (m_aw_valid),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .s_aw_ready (s_aw_ready),
        .s_w_ready  (s_w_ready),
        .m_aw_ready (m_aw_ready),
        .m_w_ready  (m_w_ready),
        .s_aw_valid (s_aw_valid),
        .s_w_valid  (s_w_valid),
        .aw_fire    (aw_fire)
    );

    b_resp_arbiter #(
        .num_slaves (num_slaves)
    ) u_b_arb (
        .clk       (clk),
        .rstn      (rstn),
        .s_b       (s_b),
        .s_b_valid (s_b_valid),
        .m_b_ready (m_b_ready),
        .m_b       (m_b),
        .s_b_ready (s_b_ready),
        .m_b_valid (m_b_valid)
    );

endmodule

`default_nettype wire

//--- design/b_resp_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module b_resp_arbiter
    import axi_demux_pkg::*;
#(
    parameter int num_slaves = num_slaves_default,
    localparam int slave_width = (num_slaves > 1) ? $clog2(num_slaves) : 1
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  b_rsp_t [num_slaves-1:0] s_b,
    input  logic [num_slaves-1:0] s_b_valid,
    input  logic                  m_b_ready,
    output b_rsp_t                m_b,
    output logic [num_slaves-1:0] s_b_ready,
    output logic                  m_b_valid
);

    // The granted slave is held until the master takes its response
    logic                   b_locked;
    logic [slave_width-1:0] b_selected;
    logic                   grant_valid;
    logic [slave_width-1:0] grant_idx;

    // Search starts one past the last grant so every slave gets its turn
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < num_slaves; k++) begin
            idx = (int'(b_selected) + 1 + k) % num_slaves;
            if (!grant_valid && s_b_valid[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = slave_width'(idx);
            end
        end
    end

    // b_selected doubles as the rotation pointer, so it needs a defined start
    // Resetting it to the top slave makes slave 0 the first in line
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            b_locked   <= 1'b0;
            b_selected <= slave_width'(num_slaves - 1);
        end else if (b_locked) begin
            // The locked slave keeps its valid high, so master ready alone completes it
            if (m_b_ready) begin
                b_locked <= 1'b0;
            end
        end else if (grant_valid) begin
            // Arbitration only runs while no response is in flight
            // The release cycle is therefore always a bubble
            b_locked   <= 1'b1;
            b_selected <= grant_idx;
        end
    end

    assign m_b       = s_b[b_selected];
    assign m_b_valid = b_locked;

    for (genvar i = 0; i < num_slaves; i++) begin : g_ready
        assign s_b_ready[i] = b_locked && (b_selected == slave_width'(i)) && m_b_ready;
    end

endmodule

`default_nettype wire

//--- design/id_order_table.sv
`timescale 1ns/1ps
`default_nettype none

module id_order_table
    import axi_demux_pkg::*;
#(
    parameter int num_slaves = num_slaves_default,
    parameter int cnt_width  = cnt_width_default,
    localparam int slave_width = (num_slaves > 1) ? $clog2(num_slaves) : 1
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  id_t                    aw_id,
    input  logic [slave_width-1:0] aw_slave,
    input  logic                   aw_valid,
    input  logic                   aw_fire,
    input  id_t                    b_id,
    input  logic                   b_fire,
    output logic                   aw_forward
);

    // Every possible ID value owns one entry
    localparam int num_ids = 2 ** $bits(id_t);

    typedef logic [slave_width-1:0] slave_idx_t;
    typedef logic [cnt_width-1:0]   pend_cnt_t;

    // The slave that currently owns the ID and how many writes are still open there
    typedef struct packed {
        slave_idx_t slave;
        pend_cnt_t  cnt;
    } map_entry_t;

    map_entry_t [num_ids-1:0] map_q;
    map_entry_t               aw_entry;
    logic [num_ids-1:0]       cnt_up;
    logic [num_ids-1:0]       cnt_down;

    assign aw_entry = map_q[aw_id];

    // An idle ID may go anywhere
    // A busy ID may only follow its earlier writes to the same slave, and only below the limit
    assign aw_forward = aw_valid && ((aw_entry.cnt == '0) ||
                        ((aw_entry.slave == aw_slave) && (aw_entry.cnt != '1)));

    for (genvar i = 0; i < num_ids; i++) begin : g_entry
        // Decode the AW and B handshakes onto the entry they belong to
        assign cnt_up[i]   = aw_fire && (aw_id == id_t'(i));
        assign cnt_down[i] = b_fire && (b_id == id_t'(i));

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                map_q[i] <= '0;
            end else if (cnt_up[i]) begin
                // The slave is rewritten on every AW and can only differ when the count was zero
                map_q[i].slave <= aw_slave;
                // A response retiring in the same cycle cancels the increment
                if (!cnt_down[i]) begin
                    map_q[i].cnt <= map_q[i].cnt + 1'b1;
                end
            end else if (cnt_down[i]) begin
                map_q[i].cnt <= map_q[i].cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- list.f
design/axi_demux_pkg.sv
design/aw_addr_decode.sv
design/id_order_table.sv
design/aw_w_router.sv
design/b_resp_arbiter.sv
design/axi_wr_demux.sv
sim/tb_clock_gen.sv
sim/axi_wr_demux_asserts.sv
sim/tb_axi_wr_demux.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_axi_wr_demux \
    && ./obj_dir/Vtb_axi_wr_demux | tee /dev/stderr \
        | grep -qx "Simulation completed successfully" \
    && echo "Run passed" \
    || { echo "Run did not pass"; exit 1; }

//--- sim/axi_wr_demux_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_demux_asserts
    import axi_demux_pkg::*;
#(
    parameter int num_slaves = num_slaves_default
) (
    input logic                    clk,
    input logic                    rstn,
    input b_rsp_t                  m_b,
    input logic                    m_b_valid,
    input logic                    m_b_ready,
    input aw_req_t [num_slaves-1:0] s_aw,
    input logic [num_slaves-1:0]   s_aw_valid,
    input logic [num_slaves-1:0]   s_aw_ready
);

    // A stalled AW toward a slave keeps its valid and its payload
    for (genvar i = 0; i < num_slaves; i++) begin : g_aw_hold
        assert property (@(posedge clk) disable iff (!rstn)
            s_aw_valid[i] && !s_aw_ready[i] |=> s_aw_valid[i] && $stable(s_aw[i]))
        else $error("AW toward slave %0d changed before its handshake", i);
    end

    // A stalled response toward the master is held in the same way
    assert property (@(posedge clk) disable iff (!rstn)
        m_b_valid && !m_b_ready |=> m_b_valid && $stable(m_b))
    else $error("B toward the master changed before its handshake");

    // The first three cycles after reset release see no AW at any slave
    assert property (@(posedge clk)
        (!$past(rstn, 1) || !$past(rstn, 2) || !$past(rstn, 3)) |-> (s_aw_valid == '0))
    else $error("AW valid raised within three cycles of reset release");

endmodule

`default_nettype wire

//--- sim/tb_axi_wr_demux.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_demux
    import axi_demux_pkg::*;
#(
    parameter int n_writes = 300
) ();

    localparam int num_slaves  = 3;
    localparam int max_pending = 3;
    localparam int clk_period  = 8;
    localparam int num_ids     = 16;
    // Windows of slave 2, 1 and 0; the region at 0x1000_0000 matches none of them
    localparam addr_t [num_slaves-1:0] base_cfg = {32'h0002_0000, 32'h0001_0000, 32'h0000_0000};
    localparam addr_t [num_slaves-1:0] mask_cfg = {32'h0001_ffff, 32'h0000_ffff, 32'h0000_ffff};

    logic                     clk;
    logic                     rstn;
    aw_req_t                  m_aw;
    logic                     m_aw_valid;
    logic                     m_aw_ready;
    w_beat_t                  m_w;
    logic                     m_w_valid;
    logic                     m_w_ready;
    b_rsp_t                   m_b;
    logic                     m_b_valid;
    logic                     m_b_ready;
    aw_req_t [num_slaves-1:0] s_aw;
    logic [num_slaves-1:0]    s_aw_valid;
    logic [num_slaves-1:0]    s_aw_ready;
    w_beat_t [num_slaves-1:0] s_w;
    logic [num_slaves-1:0]    s_w_valid;
    logic [num_slaves-1:0]    s_w_ready;
    b_rsp_t [num_slaves-1:0]  s_b;
    logic [num_slaves-1:0]    s_b_valid;
    logic [num_slaves-1:0]    s_b_ready;

    // Reference model of the pending writes per ID and the slave that holds them
    logic [31:0] rng_state;
    int          errors;
    int          cyc;
    int          issued;
    int          responses;
    int          pend_cnt [num_ids];
    int          pend_slave [num_ids];
    // Slave models keep bursts waiting for W, then responses waiting for their due cycle
    id_t         aw_ids [num_slaves][$];
    id_t         b_ids [num_slaves][$];
    int          b_due [num_slaves][$];
    // The write the master is currently sending
    aw_req_t     cur;
    data_t       cur_data [4];
    strb_t       cur_strb [4];
    logic        cur_active;
    logic        aw_done;
    int          beats_sent;
    int          beats_seen;
    int          aw_hits;
    int          cur_slave;

    tb_clock_gen #(.period_ns(clk_period), .reset_cycles(3)) u_clk (.clk(clk), .rstn(rstn));

    axi_wr_demux #(
        .num_slaves (num_slaves),
        .cnt_width  (2),
        .slave_base (base_cfg),
        .slave_mask (mask_cfg)
    ) dut (.*);

    bind axi_wr_demux axi_wr_demux_asserts #(.num_slaves(num_slaves)) u_asserts (
        .clk        (clk),
        .rstn       (rstn),
        .m_b        (m_b),
        .m_b_valid  (m_b_valid),
        .m_b_ready  (m_b_ready),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready)
    );

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // The upper bits of the LCG are the better distributed ones
    function automatic int rand_below(input int n);
        return int'(rand_next() >> 16) % n;
    endfunction

    // Lowest window with a nonzero mask wins and no match means slave 0
    function automatic int window_of(input addr_t addr);
        for (int i = 0; i < num_slaves; i++) begin
            if (mask_cfg[i] != '0 && (addr & ~mask_cfg[i]) == base_cfg[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("FAILED %s: expected %0h, actual %0h", what, exp, act);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Error at cycle %0d: %s", cyc, msg);
    endtask

    task automatic check_slave_aw(input int i);
        int id;
        id = int'(s_aw[i].id);
        aw_hits++;
        if (s_aw[i] != cur) begin
            report_mismatch("aw_payload", 64'(cur), 64'(s_aw[i]));
        end
        if (window_of(s_aw[i].addr) != i) begin
            report_mismatch("aw_slave", 64'(window_of(s_aw[i].addr)), 64'(i));
        end
        if (pend_cnt[id] > 0 && pend_slave[id] != i) begin
            note_failure($sformatf("ID %0d reached slave %0d while pending at slave %0d",
                                   id, i, pend_slave[id]));
        end
        if (pend_cnt[id] >= max_pending) begin
            note_failure($sformatf("ID %0d exceeded %0d pending writes", id, max_pending));
        end
        pend_cnt[id]++;
        pend_slave[id] = i;
        aw_ids[i].push_back(s_aw[i].id);
    endtask

    task automatic check_slave_w(input int i);
        int k;
        k = beats_seen;
        if (i != cur_slave) begin
            report_mismatch("w_slave", 64'(cur_slave), 64'(i));
        end
        if (aw_ids[i].size() == 0) begin
            note_failure($sformatf("W beat reached slave %0d with no AW accepted", i));
        end else if (k > int'(cur.len)) begin
            note_failure($sformatf("Extra W beat at slave %0d", i));
        end else begin
            if (s_w[i].data != cur_data[k]) begin
                report_mismatch("w_data", 64'(cur_data[k]), 64'(s_w[i].data));
            end
            if (s_w[i].strb != cur_strb[k]) begin
                report_mismatch("w_strb", 64'(cur_strb[k]), 64'(s_w[i].strb));
            end
            if (s_w[i].last != (k == int'(cur.len))) begin
                report_mismatch("w_last", 64'(k == int'(cur.len)), 64'(s_w[i].last));
            end
        end
        beats_seen++;
        // The burst is complete, so the slave schedules its response
        if (s_w[i].last && aw_ids[i].size() > 0) begin
            b_ids[i].push_back(aw_ids[i].pop_front());
            b_due[i].push_back(cyc + rand_below(6));
        end
    endtask

    // Called just before the rising edge, while every handshake of that edge is settled
    task automatic sample_edge();
        int id;
        cyc++;
        if (m_b_valid && m_b_ready) begin
            id = int'(m_b.id);
            responses++;
            if (pend_cnt[id] == 0) begin
                note_failure($sformatf("Response for ID %0d with no write pending", id));
            end else begin
                if (int'(m_b.resp) != pend_slave[id]) begin
                    report_mismatch("b_resp", 64'(pend_slave[id]), 64'(m_b.resp));
                end
                pend_cnt[id]--;
            end
        end
        if (m_aw_valid && m_aw_ready) begin
            aw_done = 1'b1;
        end
        if (m_w_valid && m_w_ready) begin
            beats_sent++;
        end
        for (int i = 0; i < num_slaves; i++) begin
            if (s_aw_valid[i] && s_aw_ready[i]) begin
                check_slave_aw(i);
            end
            if (s_w_valid[i] && s_w_ready[i]) begin
                check_slave_w(i);
            end
            if (s_b_valid[i] && s_b_ready[i]) begin
                void'(b_ids[i].pop_front());
                void'(b_due[i].pop_front());
            end
        end
    endtask

    task automatic start_write();
        cur.id = id_t'(rand_below(3));
        case (rand_below(4))
            0: cur.addr = 32'h0000_0000 | (rand_next() & 32'h0000_fffc);
            1: cur.addr = 32'h0001_0000 | (rand_next() & 32'h0000_fffc);
            2: cur.addr = 32'h0002_0000 | (rand_next() & 32'h0001_fffc);
            default: cur.addr = 32'h1000_0000 | (rand_next() & 32'h00ff_fffc);
        endcase
        cur.len = len_t'(rand_below(4));
        for (int k = 0; k < 4; k++) begin
            cur_data[k] = rand_next();
            cur_strb[k] = strb_t'(rand_next() >> 20);
        end
        cur_slave  = window_of(cur.addr);
        cur_active = 1'b1;
        aw_done    = 1'b0;
        beats_sent = 0;
        beats_seen = 0;
        aw_hits    = 0;
        issued++;
        m_aw       = cur;
        m_aw_valid = 1'b1;
    endtask

    task automatic finish_write();
        if (aw_hits != 1) begin
            report_mismatch("aw_count", 64'(1), 64'(aw_hits));
        end
        if (beats_seen != int'(cur.len) + 1) begin
            report_mismatch("w_count", 64'(int'(cur.len) + 1), 64'(beats_seen));
        end
        cur_active = 1'b0;
        m_aw_valid = 1'b0;
        m_w_valid  = 1'b0;
    endtask

    // Called at the falling edge to drive every DUT input for the next rising edge
    task automatic drive_edge();
        if (cur_active && aw_done && beats_sent > int'(cur.len)) begin
            finish_write();
        end
        if (!cur_active && issued < n_writes) begin
            start_write();
        end
        if (cur_active) begin
            if (aw_done) begin
                m_aw_valid = 1'b0;
            end
            if (beats_sent > int'(cur.len)) begin
                m_w_valid = 1'b0;
            end else begin
                m_w.data  = cur_data[beats_sent];
                m_w.strb  = cur_strb[beats_sent];
                m_w.last  = (beats_sent == int'(cur.len));
                m_w_valid = 1'b1;
            end
        end
        for (int i = 0; i < num_slaves; i++) begin
            s_aw_ready[i] = (rand_below(2) != 0);
            // A slave takes W only for a burst whose AW it already holds
            s_w_ready[i] = (aw_ids[i].size() > 0) && (rand_below(2) != 0);
            if (b_ids[i].size() > 0 && b_due[i][0] <= cyc) begin
                s_b_valid[i]  = 1'b1;
                s_b[i].id     = b_ids[i][0];
                s_b[i].resp   = resp_t'(i);
            end else begin
                s_b_valid[i] = 1'b0;
            end
        end
        m_b_ready = (rand_below(4) != 0);
    endtask

    function automatic logic all_done();
        int open;
        open = 0;
        for (int id = 0; id < num_ids; id++) begin
            open += pend_cnt[id];
        end
        return issued == n_writes && !cur_active && open == 0;
    endfunction

    initial begin
        rng_state  = 32'd21;
        errors     = 0;
        cyc        = 0;
        issued     = 0;
        responses  = 0;
        cur        = '0;
        cur_active = 1'b0;
        aw_done    = 1'b0;
        m_aw       = '0;
        m_aw_valid = 1'b0;
        m_w        = '0;
        m_w_valid  = 1'b0;
        m_b_ready  = 1'b0;
        s_aw_ready = '0;
        s_w_ready  = '0;
        s_b        = '0;
        s_b_valid  = '0;
        for (int id = 0; id < num_ids; id++) begin
            pend_cnt[id]   = 0;
            pend_slave[id] = 0;
        end
        @(posedge rstn);
        // Quiet cycles after reset so the DUT can be seen idle
        repeat (3) @(negedge clk);
        while (!all_done()) begin
            drive_edge();
            // Outputs have settled one nanosecond ahead of the rising edge
            #(clk_period / 2 - 1);
            sample_edge();
            @(negedge clk);
        end
        for (int i = 0; i < num_slaves; i++) begin
            if (aw_ids[i].size() != 0 || b_ids[i].size() != 0) begin
                note_failure($sformatf("Slave %0d still holds unfinished writes", i));
            end
        end
        $display("Writes %0d, responses %0d, errors %0d", issued, responses, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Far beyond the time the longest write and its response can take
    initial begin
        #(n_writes * 60 * clk_period);
        $display("Watchdog expired with %0d of %0d writes issued and %0d responses",
                 issued, n_writes, responses);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset is released on a falling edge so it never races the rising edge
    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire
